//--- include/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// rob geometry
`define ROB_INDEX_BITS 6
`define ROB_DEPTH 64

// dispatch width, also the number of banks
`define ISSUE_WIDTH 4
`define BANK_ROWS 16   // ROB_DEPTH / ISSUE_WIDTH

// unresolved branches in flight
`define MAX_BRANCHES 2

`define INSTR_TAG_BITS 8

`endif

//--- source/rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

   typedef logic [`INSTR_TAG_BITS-1:0] instr_tag_t;
   typedef logic [`ROB_INDEX_BITS-1:0] rob_idx_t;
   typedef logic [`ROB_INDEX_BITS:0] rob_ptr_t;   // msb is the wrap bit
   typedef logic [$clog2(`BANK_ROWS)-1:0] bank_row_t;

   // one instruction offered at dispatch
   typedef struct packed {
      logic valid;
      logic is_branch;
      instr_tag_t tag;
   } disp_slot_t;

   typedef disp_slot_t [`ISSUE_WIDTH-1:0] disp_bundle_t;

   typedef struct packed {
      logic valid;
      logic done;
      logic is_branch;
      logic mispred;   // only meaningful on branches
      instr_tag_t tag;
   } rob_entry_t;

   typedef struct packed {
      logic enable;
      bank_row_t row;
      rob_entry_t entry;
   } bank_write_t;

   // group handed to the commit sink, tags[0] is the oldest
   typedef struct packed {
      logic [2:0] count;
      instr_tag_t [`ISSUE_WIDTH-1:0] tags;
      logic branch;    // last entry is a branch
      logic mispred;
   } commit_bundle_t;

   typedef struct packed {
      logic strobe;
      logic [2:0] count;
   } retire_t;

endpackage

//--- source/branch_pkg.sv
`include "rob_settings.svh"

package branch_pkg;

   typedef logic [`ROB_INDEX_BITS-1:0] brnc_idx_t;

   // tracker slot, rob index of an unresolved branch
   typedef struct packed {
      logic valid;
      brnc_idx_t idx;
   } brnc_tag_t;

   typedef brnc_tag_t [`MAX_BRANCHES-1:0] br_alloc_t;   // [0] is older

   // single cycle completion pulse from execute
   typedef struct packed {
      logic valid;
      brnc_idx_t idx;
      logic mispred;
   } cmpl_t;

   // circular range [from_idx, to_idx) to squash
   typedef struct packed {
      logic valid;
      brnc_idx_t from_idx;
      brnc_idx_t to_idx;
   } flush_t;

endpackage

//--- source/dispatch_alloc.sv
`include "rob_settings.svh"

module dispatch_alloc
(
   input  logic                                     clk,
   input  logic                                     rst_n,
   input  logic                                     disp_req,
   input  rob_pkg::disp_bundle_t                    disp_bundle,
   output logic                                     disp_ack,
   input  rob_pkg::rob_ptr_t                        rob_head,
   input  logic [1:0]                               br_free,
   input  branch_pkg::cmpl_t                        cmpl,
   output rob_pkg::bank_write_t [`ISSUE_WIDTH-1:0]  bank_wr,
   output branch_pkg::br_alloc_t                    br_alloc,
   output branch_pkg::flush_t                       flush
);

   rob_pkg::rob_ptr_t tail;
   rob_pkg::rob_ptr_t free_cnt;
   rob_pkg::rob_idx_t slot_idx [`ISSUE_WIDTH];
   rob_pkg::rob_idx_t rewind;   // entries younger than the branch
   logic [2:0] n_valid;
   logic [2:0] n_br;
   logic mispred;
   logic fits;
   logic accept;

   assign mispred = cmpl.valid & cmpl.mispred;

   always_comb
   begin
      n_valid = '0;
      n_br = '0;
      for (int k = 0; k < `ISSUE_WIDTH; k++)
      begin
         slot_idx[k] = tail[`ROB_INDEX_BITS-1:0] + rob_pkg::rob_idx_t'(k);
         n_valid += 3'(disp_bundle[k].valid);
         n_br += 3'(disp_bundle[k].valid & disp_bundle[k].is_branch);
      end
   end

   assign free_cnt = rob_pkg::rob_ptr_t'(`ROB_DEPTH) - (tail - rob_head);
   assign fits = (free_cnt >= rob_pkg::rob_ptr_t'(n_valid)) && ({1'b0, br_free} >= n_br);
   assign accept = disp_req & ~disp_ack & fits & ~mispred;   // mispredict wins the cycle

   // slot k lands in bank (tail+k)%4, all four banks differ
   always_comb
   begin
      bank_wr = '0;
      for (int k = 0; k < `ISSUE_WIDTH; k++)
      begin
         bank_wr[slot_idx[k][1:0]].enable = accept & disp_bundle[k].valid;
         bank_wr[slot_idx[k][1:0]].row = slot_idx[k][`ROB_INDEX_BITS-1:2];
         bank_wr[slot_idx[k][1:0]].entry.valid = 1'b1;
         bank_wr[slot_idx[k][1:0]].entry.is_branch = disp_bundle[k].is_branch;
         bank_wr[slot_idx[k][1:0]].entry.tag = disp_bundle[k].tag;
      end
   end

   // first two branches in program order
   always_comb
   begin
      br_alloc = '0;
      for (int k = 0; k < `ISSUE_WIDTH; k++)
      begin
         if (accept && disp_bundle[k].valid && disp_bundle[k].is_branch)
         begin
            if (!br_alloc[0].valid)
               br_alloc[0] = '{valid: 1'b1, idx: slot_idx[k]};
            else if (!br_alloc[1].valid)
               br_alloc[1] = '{valid: 1'b1, idx: slot_idx[k]};
         end
      end
   end

   assign rewind = tail[`ROB_INDEX_BITS-1:0] - cmpl.idx - 1'b1;

   assign flush.valid = mispred;
   assign flush.from_idx = cmpl.idx + 1'b1;
   assign flush.to_idx = tail[`ROB_INDEX_BITS-1:0];   // old tail, exclusive

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tail <= '0;
         disp_ack <= 1'b0;
      end
      else
      begin
         if (mispred)
            tail <= tail - rob_pkg::rob_ptr_t'(rewind);   // back to branch + 1
         else if (accept)
            tail <= tail + rob_pkg::rob_ptr_t'(n_valid);

         if (accept)
            disp_ack <= 1'b1;
         else if (!disp_req)
            disp_ack <= 1'b0;   // req seen low
      end
   end

endmodule

//--- source/rob_bank.sv
`include "rob_settings.svh"

module rob_bank
#(
   parameter int BANK_ID = 0
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  rob_pkg::bank_write_t  bank_wr,
   input  branch_pkg::cmpl_t     cmpl,
   input  branch_pkg::flush_t    flush,
   input  rob_pkg::rob_ptr_t     rob_head,
   input  rob_pkg::retire_t      retire,
   output rob_pkg::rob_entry_t   head_entry
);

   localparam logic [1:0] LANE = 2'(BANK_ID);

   rob_pkg::rob_entry_t entries [`BANK_ROWS];
   rob_pkg::rob_idx_t head_idx;
   rob_pkg::rob_idx_t lane_idx;
   rob_pkg::rob_idx_t flush_len;
   logic [1:0] lane_ofs;
   logic [`BANK_ROWS-1:0] clr;
   logic [`BANK_ROWS-1:0] hit;

   // oldest index at or after head that lives in this bank
   assign head_idx = rob_head[`ROB_INDEX_BITS-1:0];
   assign lane_ofs = LANE - head_idx[1:0];
   assign lane_idx = head_idx + rob_pkg::rob_idx_t'(lane_ofs);
   assign head_entry = entries[lane_idx[`ROB_INDEX_BITS-1:2]];

   assign flush_len = flush.to_idx - flush.from_idx;

   for (genvar r = 0; r < `BANK_ROWS; r++)
   begin : g_row
      rob_pkg::rob_idx_t idx;

      assign idx = {rob_pkg::bank_row_t'(r), LANE};
      // circular range tests, 6 bit wrap
      assign clr[r] = (flush.valid && ((idx - flush.from_idx) < flush_len)) ||
                      (retire.strobe && ((idx - head_idx) < rob_pkg::rob_idx_t'(retire.count)));
      assign hit[r] = cmpl.valid && (cmpl.idx == idx);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < `BANK_ROWS; r++)
            entries[r] <= '0;
      end
      else
      begin
         for (int r = 0; r < `BANK_ROWS; r++)
         begin
            if (clr[r])
               entries[r] <= '0;
            else if (bank_wr.enable && (bank_wr.row == rob_pkg::bank_row_t'(r)))
               entries[r] <= bank_wr.entry;
            else if (hit[r] && entries[r].valid)
            begin
               entries[r].done <= 1'b1;
               entries[r].mispred <= cmpl.mispred;
            end
         end
      end
   end

endmodule

//--- source/commit_retire.sv
`include "rob_settings.svh"

module commit_retire
(
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  rob_pkg::rob_entry_t [`ISSUE_WIDTH-1:0]  head_entry,
   output logic                                    commit_req,
   input  logic                                    commit_ack,
   output rob_pkg::commit_bundle_t                 commit_bundle,
   output rob_pkg::rob_ptr_t                       rob_head,
   output rob_pkg::retire_t                        retire,
   output branch_pkg::brnc_tag_t                   br_commit
);

   typedef enum logic [1:0]
   {
      ST_IDLE,
      ST_REQ,    // req high, waiting for ack
      ST_WAIT    // waiting for ack to drop
   } state_t;

   state_t state;
   rob_pkg::rob_entry_t [`ISSUE_WIDTH-1:0] aged;
   rob_pkg::commit_bundle_t group;
   logic grp_open;
   logic start;

   // aged[0] is the entry at the head
   always_comb
   begin
      for (int k = 0; k < `ISSUE_WIDTH; k++)
         aged[k] = head_entry[rob_head[1:0] + 2'(k)];
   end

   // consecutive done entries, closed by the first branch
   always_comb
   begin
      group = '0;
      grp_open = 1'b1;
      for (int k = 0; k < `ISSUE_WIDTH; k++)
      begin
         if (grp_open && aged[k].valid && aged[k].done)
         begin
            group.count = 3'(k + 1);
            group.tags[k] = aged[k].tag;
            group.branch = aged[k].is_branch;
            group.mispred = aged[k].mispred;
            if (aged[k].is_branch)
               grp_open = 1'b0;
         end
         else
            grp_open = 1'b0;
      end
   end

   assign start = (state == ST_IDLE) && (group.count != '0);
   assign commit_req = (state == ST_REQ);

   assign retire.strobe = commit_req & commit_ack;
   assign retire.count = commit_bundle.count;

   // last entry of the group is the branch
   assign br_commit.valid = retire.strobe & commit_bundle.branch;
   assign br_commit.idx = rob_head[`ROB_INDEX_BITS-1:0] +
                          rob_pkg::rob_idx_t'(commit_bundle.count) - 1'b1;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= ST_IDLE;
         rob_head <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (start)
                  state <= ST_REQ;
            end
            ST_REQ:
            begin
               if (commit_ack)
               begin
                  rob_head <= rob_head + rob_pkg::rob_ptr_t'(commit_bundle.count);
                  state <= ST_WAIT;
               end
            end
            ST_WAIT:
            begin
               if (!commit_ack)
                  state <= ST_IDLE;
            end
            default:
               state <= ST_IDLE;
         endcase
      end
   end

   // held stable for the whole handshake
   always_ff @(posedge clk)
   begin
      if (start)
         commit_bundle <= group;
   end

endmodule

//--- source/branch_fifo.sv
`include "rob_settings.svh"

module branch_fifo
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  branch_pkg::br_alloc_t  br_alloc,
   input  branch_pkg::brnc_tag_t  br_commit,
   input  branch_pkg::cmpl_t      cmpl,
   output logic [1:0]             br_free
);

   branch_pkg::brnc_tag_t [`MAX_BRANCHES-1:0] slots;
   logic head;    // oldest branch
   logic tail;    // next slot to fill
   logic young;
   logic head_match_cmt;
   logic head_match_mis;
   logic pop_head;
   logic drop_young;
   logic [1:0] n_alloc;

   assign young = head + 1'b1;

   assign head_match_cmt = slots[head].valid && (br_commit.idx == slots[head].idx);
   assign head_match_mis = slots[head].valid && (cmpl.idx == slots[head].idx);

   // oldest branch retired
   assign pop_head = br_commit.valid && head_match_cmt;
   // oldest mispredicted, so the younger one is on the wrong path
   assign drop_young = cmpl.valid && cmpl.mispred && head_match_mis && slots[young].valid;

   assign n_alloc = 2'(br_alloc[0].valid) + 2'(br_alloc[1].valid);
   assign br_free = 2'(!slots[0].valid) + 2'(!slots[1].valid);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         slots <= '0;
         head <= 1'b0;
         tail <= 1'b0;
      end
      else
      begin
         if (pop_head)
         begin
            slots[head].valid <= 1'b0;
            head <= young;
         end

         if (drop_young)
         begin
            slots[young].valid <= 1'b0;
            tail <= young;
         end
         else if (n_alloc != 2'd0)
         begin
            slots[tail] <= br_alloc[0];
            if (br_alloc[1].valid)
               slots[tail + 1'b1] <= br_alloc[1];
            tail <= tail + n_alloc[0];   // two slots wrap back to tail
         end
      end
   end

endmodule

//--- source/rob_branch_unit.sv
`include "rob_settings.svh"

module rob_branch_unit
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     disp_req,
   input  rob_pkg::disp_bundle_t    disp_bundle,
   output logic                     disp_ack,
   input  branch_pkg::cmpl_t        cmpl,
   output logic                     commit_req,
   input  logic                     commit_ack,
   output rob_pkg::commit_bundle_t  commit_bundle
);

   rob_pkg::bank_write_t [`ISSUE_WIDTH-1:0] bank_wr;
   rob_pkg::rob_entry_t [`ISSUE_WIDTH-1:0] head_entry;
   rob_pkg::rob_ptr_t rob_head;
   rob_pkg::retire_t retire;
   branch_pkg::br_alloc_t br_alloc;
   branch_pkg::brnc_tag_t br_commit;
   branch_pkg::flush_t flush;
   logic [1:0] br_free;

   dispatch_alloc u_dispatch_alloc
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .disp_req    (disp_req),
      .disp_bundle (disp_bundle),
      .disp_ack    (disp_ack),
      .rob_head    (rob_head),
      .br_free     (br_free),
      .cmpl        (cmpl),
      .bank_wr     (bank_wr),
      .br_alloc    (br_alloc),
      .flush       (flush)
   );

   for (genvar b = 0; b < `ISSUE_WIDTH; b++)
   begin : g_bank
      rob_bank
      #(
         .BANK_ID (b)
      )
      u_rob_bank
      (
         .clk        (clk),
         .rst_n      (rst_n),
         .bank_wr    (bank_wr[b]),
         .cmpl       (cmpl),
         .flush      (flush),
         .rob_head   (rob_head),
         .retire     (retire),
         .head_entry (head_entry[b])
      );
   end

   commit_retire u_commit_retire
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .head_entry    (head_entry),
      .commit_req    (commit_req),
      .commit_ack    (commit_ack),
      .commit_bundle (commit_bundle),
      .rob_head      (rob_head),
      .retire        (retire),
      .br_commit     (br_commit)
   );

   branch_fifo u_branch_fifo
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .br_alloc  (br_alloc),
      .br_commit (br_commit),
      .cmpl      (cmpl),
      .br_free   (br_free)
   );

endmodule

//--- verif/tb_rob_branch_unit.sv
`include "rob_settings.svh"

module tb_rob_branch_unit;

   localparam int HALF_PERIOD = 20;
   // rough cycles per test in run order
   localparam int TEST_CYCLES = 20 + 200 + 300 + 700 + 200 + 2500;

   typedef struct packed {
      logic [`INSTR_TAG_BITS-1:0] tag;
      logic [`ROB_INDEX_BITS-1:0] idx;
      logic branch;
      logic mispred;
   } ref_t;

   logic clk = 1'b0;
   logic rst_n;
   logic disp_req;
   rob_pkg::disp_bundle_t disp_bundle;
   logic disp_ack;
   branch_pkg::cmpl_t cmpl;
   logic commit_req;
   logic commit_ack = 1'b0;
   rob_pkg::commit_bundle_t commit_bundle;

   ref_t ref_q[$];                          // accepted but not yet committed
   logic [`ROB_INDEX_BITS-1:0] pend[$];     // accepted but not yet completed
   logic [`ROB_INDEX_BITS-1:0] tail_idx = '0;
   logic [`INSTR_TAG_BITS-1:0] next_tag = 'h10;
   rob_pkg::disp_bundle_t offered;
   logic sink_hold = 1'b0;                  // holds commit_ack low
   int ack_wait = 0;
   int errors = 0;
   int n_disp = 0;
   int n_commit = 0;
   string test_name = "reset";

   rob_branch_unit uut
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .disp_req      (disp_req),
      .disp_bundle   (disp_bundle),
      .disp_ack      (disp_ack),
      .cmpl          (cmpl),
      .commit_req    (commit_req),
      .commit_ack    (commit_ack),
      .commit_bundle (commit_bundle)
   );

   always #HALF_PERIOD clk = ~clk;

   task automatic flag_mismatch(input string what, input int expected, input int actual);
      errors++;
      $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
   endtask

   task automatic flag_error(input string what);
      errors++;
      $display("ERROR in %s: %s", test_name, what);
   endtask

   task automatic offer(input int n, input logic [3:0] br);
      rob_pkg::disp_bundle_t b;
      b = '0;
      for (int k = 0; k < n; k++)
      begin
         b[k].valid = 1'b1;
         b[k].is_branch = br[k];
         b[k].tag = next_tag;
         next_tag++;
      end
      offered = b;
      @(posedge clk);
      disp_bundle <= b;
      disp_req <= 1'b1;
   endtask

   // books the acked bundle at the model tail and closes the handshake
   task automatic take_ack(output int waited);
      ref_t r;
      int n;
      waited = 0;
      n = 0;
      do
      begin
         @(posedge clk);
         waited++;
      end
      while (!disp_ack);
      for (int k = 0; k < `ISSUE_WIDTH; k++)
      begin
         if (offered[k].valid)
         begin
            r = '{offered[k].tag, tail_idx + `ROB_INDEX_BITS'(k), offered[k].is_branch, 1'b0};
            ref_q.push_back(r);
            pend.push_back(r.idx);
            n++;
         end
      end
      tail_idx = tail_idx + `ROB_INDEX_BITS'(n);
      n_disp += n;
      disp_req <= 1'b0;
      do
         @(posedge clk);
      while (disp_ack);
   endtask

   task automatic check_no_ack(input int cycles);
      repeat (cycles)
      begin
         @(posedge clk);
         if (disp_ack)
            flag_error("dispatch was acked while it should stall");
      end
   endtask

   task automatic complete(input logic [`ROB_INDEX_BITS-1:0] idx, input logic mis);
      @(posedge clk);
      cmpl <= '{1'b1, idx, mis};
      @(posedge clk);
      cmpl <= '0;
   endtask

   // younger instructions leave the model and the tail goes back to branch + 1
   task automatic mispredict(input logic [`ROB_INDEX_BITS-1:0] idx);
      ref_t r;
      int pos;
      pos = -1;
      foreach (ref_q[i])
      begin
         if (ref_q[i].idx == idx)
            pos = i;
      end
      if (pos < 0)
         flag_error("mispredicted branch is not outstanding");
      else
      begin
         r = ref_q[pos];
         r.mispred = 1'b1;
         ref_q[pos] = r;
         n_disp -= ref_q.size() - pos - 1;
         while (ref_q.size() > pos + 1)
            void'(ref_q.pop_back());
         tail_idx = idx + 1'b1;
      end
      complete(idx, 1'b1);
   endtask

   task automatic complete_pending();
      logic [`ROB_INDEX_BITS-1:0] t;
      int j;
      for (int i = pend.size() - 1; i > 0; i--)
      begin
         j = int'($urandom % (i + 1));
         t = pend[i];
         pend[i] = pend[j];
         pend[j] = t;
      end
      foreach (pend[i])
         complete(pend[i], 1'b0);
      pend.delete();
   endtask

   task automatic drain();
      while (ref_q.size() != 0 || commit_req || commit_ack)
         @(posedge clk);
      repeat (4) @(posedge clk);
      if (n_commit != n_disp)
         flag_mismatch("committed count", n_disp, n_commit);
   endtask

   task automatic check_group(input rob_pkg::commit_bundle_t cb);
      logic last_br;
      logic last_mis;
      last_br = 1'b0;
      last_mis = 1'b0;
      if (cb.count == 0 || cb.count > `ISSUE_WIDTH)
         flag_error("commit group has an illegal count");
      for (int i = 0; i < int'(cb.count); i++)
      begin
         if (ref_q.size() == 0)
            flag_error("commit with no instruction outstanding");
         else
         begin
            if (cb.tags[i] !== ref_q[0].tag)
               flag_mismatch("commit tag", ref_q[0].tag, cb.tags[i]);
            if (ref_q[0].branch && i != int'(cb.count) - 1)
               flag_error("commit group continues past a branch");
            last_br = ref_q[0].branch;
            last_mis = ref_q[0].mispred;
            void'(ref_q.pop_front());
         end
      end
      if (cb.branch !== last_br)
         flag_mismatch("branch flag", last_br, cb.branch);
      if (cb.mispred !== (last_br & last_mis))
         flag_mismatch("mispred flag", last_br & last_mis, cb.mispred);
      n_commit += int'(cb.count);
   endtask

   // four-phase commit sink acking after 0 to 3 cycles
   always @(posedge clk)
   begin
      if (commit_ack)
      begin
         if (!commit_req)
            commit_ack <= 1'b0;
      end
      else if (commit_req && !sink_hold)
      begin
         if (ack_wait == 0)
         begin
            check_group(commit_bundle);
            commit_ack <= 1'b1;
            ack_wait <= int'($urandom % 4);
         end
         else
            ack_wait <= ack_wait - 1;
      end
   end

   task automatic test_reset();
      test_name = "reset";
      repeat (10) @(posedge clk);
      if (disp_ack !== 1'b0)
         flag_error("disp_ack is high after reset");
      if (commit_req !== 1'b0)
         flag_error("commit_req is high after reset");
      if (n_commit != 0)
         flag_error("a commit happened with nothing dispatched");
   endtask

   task automatic test_in_order();
      int w;
      test_name = "in_order";
      offer(4, 4'b0000);
      take_ack(w);
      offer(3, 4'b0000);
      take_ack(w);
      offer(4, 4'b0000);
      take_ack(w);
      complete_pending();
      drain();
   endtask

   task automatic test_branch_stall();
      logic [`ROB_INDEX_BITS-1:0] oldest;
      int w;
      test_name = "branch_stall";
      offer(4, 4'b0101);   // tracker now full
      take_ack(w);
      oldest = pend.pop_front();
      offer(2, 4'b0000);
      take_ack(w);
      offer(2, 4'b0010);
      check_no_ack(20);
      complete(oldest, 1'b0);   // commits alone and frees a slot
      take_ack(w);
      complete_pending();
      drain();
   endtask

   task automatic test_rob_full();
      int w;
      test_name = "rob_full";
      sink_hold <= 1'b1;
      for (int i = 0; i < `ROB_DEPTH / `ISSUE_WIDTH; i++)
      begin
         offer(4, 4'b0000);
         take_ack(w);
      end
      complete_pending();
      offer(1, 4'b0000);
      check_no_ack(20);
      sink_hold <= 1'b0;
      take_ack(w);
      complete_pending();
      drain();
   endtask

   task automatic test_mispredict();
      logic [`ROB_INDEX_BITS-1:0] br_idx;
      int w;
      test_name = "mispredict";
      offer(4, 4'b1010);   // older branch in slot 1 and younger in slot 3
      take_ack(w);
      br_idx = pend[1];
      complete(pend[0], 1'b0);
      complete(pend[2], 1'b0);   // wrong path entries already done
      complete(pend[3], 1'b0);
      mispredict(br_idx);
      pend.delete();
      offer(1, 4'b0001);   // refills only the first flushed entry
      take_ack(w);
      if (w > 2)
         flag_error("branch stalled although the younger branch was flushed");
      complete_pending();
      drain();
   endtask

   task automatic test_random();
      logic [3:0] br;
      int w;
      int n;
      int nb;
      int total;
      test_name = "random";
      total = 0;
      while (total < 300)
      begin
         n = 1 + int'($urandom % 4);
         br = '0;
         nb = 0;
         for (int k = 0; k < n; k++)
         begin
            if (($urandom % 4 == 0) && (nb < `MAX_BRANCHES))
            begin
               br[k] = 1'b1;
               nb++;
            end
         end
         offer(n, br);
         take_ack(w);
         complete_pending();
         total += n;
      end
      drain();
   endtask

   initial
   begin
      void'($urandom(61));
      rst_n = 1'b0;
      disp_req = 1'b0;
      disp_bundle = '0;
      cmpl = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      test_reset();
      test_in_order();
      test_branch_stall();
      test_rob_full();
      test_mispredict();
      test_random();
      $display("errors %0d, dispatched %0d, committed %0d", errors, n_disp, n_commit);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   initial
   begin
      #(TEST_CYCLES * 2 * 2 * HALF_PERIOD);
      $display("ERROR: watchdog expired during test %s", test_name);
      $display("errors %0d, dispatched %0d, committed %0d", errors, n_disp, n_commit);
      $display("test failed");
      $finish;
   end

endmodule

//--- src.f
+incdir+include
source/rob_pkg.sv
source/branch_pkg.sv
source/dispatch_alloc.sv
source/rob_bank.sv
source/commit_retire.sv
source/branch_fifo.sv
source/rob_branch_unit.sv
verif/tb_rob_branch_unit.sv
